// File: mvu_params.svh
// geometry of the matrix-vector unit
// element, fold and result widths
// Wishbone word address map
`ifndef MVU_PARAMS_SVH
`define MVU_PARAMS_SVH

`define MVU_SIMD    4                  // lanes per fold
`define MVU_ROWS    4                  // matrix rows
`define MVU_SF      2                  // folds per row, cols / lanes
`define MVU_TSRCI   4                  // activation element width
`define MVU_TW      4                  // weight element width
`define MVU_TDST    16                 // accumulator and result width
`define MVU_FOLD_W  16                 // one fold word, 4 packed elements
`define MVU_ROW_W   ($clog2(`MVU_ROWS)) // row index width
`define MVU_FSEL_W  ($clog2(`MVU_SF))   // fold index width
`define MVU_ADR_W   6                  // bus word address width

`define MVU_A_CTRL   6'h00 // start bit 0, opcode bits 2:1
`define MVU_A_STATUS 6'h01 // busy bit 0, done bit 1
`define MVU_A_ACT    6'h08 // + fold
`define MVU_A_WGT    6'h10 // + row*2 + fold
`define MVU_A_RES    6'h20 // + row

`endif

// File: mvu_pkg.sv
// shared types of the matrix-vector unit
// run controller state enum
// lane opcode enum
package mvu_pkg;

   // run controller states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,  // waiting for start
      ST_RUN   = 2'd1,  // counter stepping through folds
      ST_DRAIN = 2'd2,  // pe pipeline emptying
      ST_DONE  = 2'd3   // results ready, sticky
   } mvu_state_e;

   // lane multiply modes, code 3 behaves as OP_MUL_S
   typedef enum logic [1:0] {
      OP_MUL_S   = 2'd0,  // signed x signed
      OP_MUL_U   = 2'd1,  // unsigned x unsigned
      OP_BIN_WGT = 2'd2   // weight bit 0 picks -1 / +1
   } mvu_op_e;

endpackage

// File: mvu_wb_regs.sv
// Wishbone classic slave of the matrix-vector unit
// one-cycle ack, start pulse and opcode latch
// row result registers and status / result read mux
// buffer write strobes, dropped while busy
`include "mvu_params.svh"

module mvu_wb_regs (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    cyc,
   input  logic                    stb,
   input  logic                    we,
   input  logic [`MVU_ADR_W-1:0]   adr,
   input  logic [31:0]             dat_w,
   input  logic                    busy,
   input  logic                    done,
   input  logic                    res_v,   // row result strobe from pe
   input  logic [`MVU_ROW_W-1:0]   res_row,
   input  logic [`MVU_TDST-1:0]    res,
   output logic [31:0]             dat_r,
   output logic                    ack,
   output logic                    start,   // one cycle, with ack
   output mvu_pkg::mvu_op_e        op,
   output logic                    buf_we,
   output logic [`MVU_ADR_W-1:0]   buf_adr,
   output logic [`MVU_FOLD_W-1:0]  buf_dat
);
   logic                   req;     // cycle seen, not yet acked
   logic                   res_hit; // adr in result window
   logic [`MVU_ADR_W-1:0]  res_off;
   logic [`MVU_TDST-1:0]   res_q [0:`MVU_ROWS-1];
   logic [`MVU_TDST-1:0]   res_rd;
   logic [31:0]            rd_mux;

   assign req     = cyc & stb & ~ack;
   assign buf_we  = req & we & ~busy;               // writes during a run are dropped
   assign buf_adr = adr;
   assign buf_dat = dat_w[`MVU_FOLD_W-1:0];
   assign res_off = adr - `MVU_A_RES;
   assign res_hit = (adr >= `MVU_A_RES) && (res_off < `MVU_ROWS);
   assign res_rd  = res_q[res_off[`MVU_ROW_W-1:0]];

   always_comb begin
      rd_mux = '0;                                  // unmapped reads give 0
      if (adr == `MVU_A_STATUS)
         rd_mux = {30'd0, done, busy};
      else if (adr == `MVU_A_CTRL)
         rd_mux = {29'd0, op, 1'b0};
      else if (res_hit)
         rd_mux = {{(32-`MVU_TDST){res_rd[`MVU_TDST-1]}}, res_rd}; // sign extended
   end

   always_ff @(posedge aclk) begin
      if (rst) begin
         ack   <= 1'b0;
         start <= 1'b0;
         op    <= mvu_pkg::OP_MUL_S;
         for (int i = 0; i < `MVU_ROWS; i++)
            res_q[i] <= '0;
      end else begin
         ack   <= req;                              // exactly one cycle per request
         start <= req & we & (adr == `MVU_A_CTRL) & dat_w[0];
         if (req && we && (adr == `MVU_A_CTRL) && !busy)
            op <= mvu_pkg::mvu_op_e'(dat_w[2:1]);   // held for the whole run
         if (res_v)
            res_q[res_row] <= res;
      end
   end

   always_ff @(posedge aclk) begin
      if (req)
         dat_r <= rd_mux;                           // valid with ack
   end

endmodule

// File: mvu_buffers.sv
// weight and activation fold storage
// written from the bus strobe, read by row and fold
`include "mvu_params.svh"

module mvu_buffers (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    buf_we,
   input  logic [`MVU_ADR_W-1:0]   buf_adr,
   input  logic [`MVU_FOLD_W-1:0]  buf_dat,
   input  logic [`MVU_ROW_W-1:0]   row,
   input  logic [`MVU_FSEL_W-1:0]  fold,
   output logic [`MVU_FOLD_W-1:0]  act_fold,
   output logic [`MVU_FOLD_W-1:0]  wgt_fold
);
   logic [`MVU_FOLD_W-1:0] act_q [0:`MVU_SF-1];            // input vector, one word per fold
   logic [`MVU_FOLD_W-1:0] wgt_q [0:`MVU_ROWS*`MVU_SF-1];  // indexed {row, fold}
   logic [`MVU_ADR_W-1:0]  act_off;
   logic [`MVU_ADR_W-1:0]  wgt_off;
   logic                   act_hit;
   logic                   wgt_hit;

   assign act_off = buf_adr - `MVU_A_ACT;
   assign wgt_off = buf_adr - `MVU_A_WGT;
   assign act_hit = (buf_adr >= `MVU_A_ACT) && (act_off < `MVU_SF);
   assign wgt_hit = (buf_adr >= `MVU_A_WGT) && (wgt_off < `MVU_ROWS * `MVU_SF);

   always_ff @(posedge aclk) begin
      if (rst) begin
         for (int i = 0; i < `MVU_SF; i++)
            act_q[i] <= '0;
         for (int i = 0; i < `MVU_ROWS * `MVU_SF; i++)
            wgt_q[i] <= '0;
      end else if (buf_we) begin
         if (act_hit)
            act_q[act_off[`MVU_FSEL_W-1:0]] <= buf_dat;
         if (wgt_hit)
            wgt_q[wgt_off[`MVU_ROW_W+`MVU_FSEL_W-1:0]] <= buf_dat;
      end
   end

   // same activation word for every row, so the input vector is reused
   assign act_fold = act_q[fold];
   assign wgt_fold = wgt_q[{row, fold}];

endmodule

// File: mvu_fold_counter.sv
// nested fold and row counter
// first / last fold flags and end-of-matrix wrap pulse
`include "mvu_params.svh"

module mvu_fold_counter (
   input  logic                    aclk,
   input  logic                    rst,
   input  logic                    cnt_en,
   output logic [`MVU_ROW_W-1:0]   row,
   output logic [`MVU_FSEL_W-1:0]  fold,
   output logic                    first,   // accumulator clear
   output logic                    last,    // row complete
   output logic                    wrap     // row 3 fold 1
);
   always_ff @(posedge aclk) begin
      if (rst || !cnt_en) begin
         row  <= '0;                           // restart from row 0 each run
         fold <= '0;
      end else if (last) begin
         fold <= '0;
         if (row == `MVU_ROWS - 1)
            row <= '0;
         else
            row <= row + 1'b1;
      end else begin
         fold <= fold + 1'b1;
      end
   end

   assign first = (fold == 0);
   assign last  = (fold == `MVU_SF - 1);
   assign wrap  = cnt_en & last & (row == `MVU_ROWS - 1);

endmodule

// File: mvu_ctrl_fsm.sv
// run controller of the matrix-vector unit
// idle, run, drain and done states
// counter enable, busy and sticky done flags
`include "mvu_params.svh"

module mvu_ctrl_fsm (
   input  logic                   aclk,
   input  logic                   rst,
   input  logic                   start,
   input  logic                   wrap,
   input  logic                   out_v,
   input  logic [`MVU_ROW_W-1:0]  out_row,
   output logic                   cnt_en,
   output logic                   busy,
   output logic                   done
);
   mvu_pkg::mvu_state_e state;
   mvu_pkg::mvu_state_e state_nxt;

   always_ff @(posedge aclk) begin
      if (rst)
         state <= mvu_pkg::ST_IDLE;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         mvu_pkg::ST_IDLE: begin
            if (start)
               state_nxt = mvu_pkg::ST_RUN;
         end
         mvu_pkg::ST_RUN: begin
            if (wrap)
               state_nxt = mvu_pkg::ST_DRAIN;  // last fold issued
         end
         mvu_pkg::ST_DRAIN: begin
            if (out_v && (out_row == `MVU_ROWS - 1))
               state_nxt = mvu_pkg::ST_DONE;   // final row result out of pe
         end
         mvu_pkg::ST_DONE: begin
            if (start)
               state_nxt = mvu_pkg::ST_RUN;    // restart clears done
         end
         default: state_nxt = mvu_pkg::ST_IDLE;
      endcase
   end

   assign cnt_en = (state == mvu_pkg::ST_RUN);
   assign busy   = (state == mvu_pkg::ST_RUN) || (state == mvu_pkg::ST_DRAIN);
   assign done   = (state == mvu_pkg::ST_DONE);

endmodule

// File: mvu_pe.sv
// processing element of the matrix-vector unit
// simd multiply lanes selected by opcode
// registered lane sum, accumulator and row tag pipeline
`include "mvu_params.svh"

module mvu_pe (
   input  logic                    aclk,
   input  logic                    rst,
   input  mvu_pkg::mvu_op_e        op,
   input  logic                    in_v,
   input  logic                    in_clr,   // first fold, load accumulator
   input  logic                    in_last,  // last fold of the row
   input  logic [`MVU_ROW_W-1:0]   in_row,
   input  logic [`MVU_FOLD_W-1:0]  in_act,   // lane 0 in the low nibble
   input  logic [`MVU_FOLD_W-1:0]  in_wgt,
   output logic                    out_v,
   output logic [`MVU_ROW_W-1:0]   out_row,
   output logic [`MVU_TDST-1:0]    out
);
   logic [`MVU_TDST-1:0]   prod [0:`MVU_SIMD-1];  // one product per lane
   logic [`MVU_TDST-1:0]   lane_sum;
   logic                   s1_v;
   logic                   s1_clr;
   logic                   s1_last;
   logic [`MVU_ROW_W-1:0]  s1_row;
   logic [`MVU_TDST-1:0]   s1_sum;
   logic [`MVU_TDST-1:0]   acc;

   for (genvar i = 0; i < `MVU_SIMD; i++) begin : g_lane
      logic [`MVU_TSRCI-1:0] a;
      logic [`MVU_TW-1:0]    w;
      logic [`MVU_TDST-1:0]  a_sx;
      logic [`MVU_TDST-1:0]  w_sx;
      logic [`MVU_TDST-1:0]  a_zx;
      logic [`MVU_TDST-1:0]  w_zx;

      assign a    = in_act[i*`MVU_TSRCI +: `MVU_TSRCI];
      assign w    = in_wgt[i*`MVU_TW +: `MVU_TW];
      assign a_sx = {{(`MVU_TDST-`MVU_TSRCI){a[`MVU_TSRCI-1]}}, a};
      assign w_sx = {{(`MVU_TDST-`MVU_TW){w[`MVU_TW-1]}}, w};
      assign a_zx = {{(`MVU_TDST-`MVU_TSRCI){1'b0}}, a};
      assign w_zx = {{(`MVU_TDST-`MVU_TW){1'b0}}, w};

      always_comb begin
         logic [`MVU_TDST-1:0] p;
         case (op)
            mvu_pkg::OP_MUL_U:   p = a_zx * w_zx;
            mvu_pkg::OP_BIN_WGT: p = w[0] ? a_sx : -a_sx;  // bit 0 means -1
            default:             p = a_sx * w_sx;          // low 16 bits exact for signed
         endcase
         prod[i] = p;
      end
   end

   // adder tree over the lanes
   always_comb begin
      lane_sum = '0;
      for (int k = 0; k < `MVU_SIMD; k++)
         lane_sum = lane_sum + prod[k];
   end

   always_ff @(posedge aclk) begin
      if (rst) begin
         s1_v  <= 1'b0;
         out_v <= 1'b0;
      end else begin
         s1_v  <= in_v;
         out_v <= s1_v & s1_last;              // once per row
      end
   end

   always_ff @(posedge aclk) begin
      s1_sum  <= lane_sum;                     // stage 1
      s1_clr  <= in_clr;
      s1_last <= in_last;
      s1_row  <= in_row;
      if (s1_v) begin                          // stage 2
         acc     <= s1_clr ? s1_sum : acc + s1_sum;
         out_row <= s1_row;
      end
   end

   assign out = acc;

endmodule

// File: mvu_top.sv
// top level of the matrix-vector unit
// bus slave, buffers, fold counter, run controller and pe
`include "mvu_params.svh"

module mvu_top (
   input  logic                   aclk,
   input  logic                   rst,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`MVU_ADR_W-1:0]  adr,
   input  logic [31:0]            dat_w,
   output logic [31:0]            dat_r,
   output logic                   ack
);
   logic                   start;
   mvu_pkg::mvu_op_e       op;
   logic                   buf_we;
   logic [`MVU_ADR_W-1:0]  buf_adr;
   logic [`MVU_FOLD_W-1:0] buf_dat;
   logic                   busy;
   logic                   done;
   logic                   cnt_en;   // also the pe input valid
   logic [`MVU_ROW_W-1:0]  row;
   logic [`MVU_FSEL_W-1:0] fold;
   logic                   first;
   logic                   last;
   logic                   wrap;
   logic [`MVU_FOLD_W-1:0] act_fold;
   logic [`MVU_FOLD_W-1:0] wgt_fold;
   logic                   out_v;
   logic [`MVU_ROW_W-1:0]  out_row;
   logic [`MVU_TDST-1:0]   pe_out;

   mvu_wb_regs u_wb_regs (
      .aclk, .rst, .cyc, .stb, .we, .adr, .dat_w,
      .busy, .done, .res_v(out_v), .res_row(out_row), .res(pe_out),
      .dat_r, .ack, .start, .op, .buf_we, .buf_adr, .buf_dat
   );

   mvu_buffers u_buffers (
      .aclk, .rst, .buf_we, .buf_adr, .buf_dat, .row, .fold, .act_fold, .wgt_fold
   );

   mvu_fold_counter u_fold_counter (
      .aclk, .rst, .cnt_en, .row, .fold, .first, .last, .wrap
   );

   mvu_ctrl_fsm u_ctrl_fsm (
      .aclk, .rst, .start, .wrap, .out_v, .out_row, .cnt_en, .busy, .done
   );

   mvu_pe u_pe (
      .aclk, .rst, .op, .in_v(cnt_en), .in_clr(first), .in_last(last), .in_row(row),
      .in_act(act_fold), .in_wgt(wgt_fold), .out_v, .out_row, .out(pe_out)
   );

endmodule

// File: mvu_checker.sv
// bus read checker of the matrix-vector unit testbench
// compares result, status and unmapped reads on ack
// per-test and closing count lines
`include "mvu_params.svh"

module mvu_checker (
   input  logic                   aclk,
   input  logic                   rst,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic                   ack,
   input  logic [`MVU_ADR_W-1:0]  adr,
   input  logic [31:0]            dat_r
);
   int                    chk_cnt;     // checks in the current test
   int                    err_cnt;     // errors in the current test
   int                    err_total;
   int                    chk_total;
   int                    test_cnt;
   logic [15:0]           e;
   logic [31:0]           want;
   logic                  rd_q;        // read request waiting for its ack
   logic [`MVU_ADR_W-1:0] adr_q;       // address of that read
   logic                  stat_q;      // exact status compare wanted
   logic [31:0]           stat_exp_q;

   initial begin
      chk_cnt   = 0;
      err_cnt   = 0;
      err_total = 0;
      chk_total = 0;
      test_cnt  = 0;
      rd_q      = 1'b0;
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Fail t=%0t %s (adr 0x%02h): got %08h expected %08h",
                  $time, name, adr_q, got, exp);
      end
   endtask

   // request taken on the edge the slave sees it, data one edge later with ack
   always @(posedge aclk) begin
      if (rst) begin
         rd_q <= 1'b0;
      end else if (cyc && stb && !ack) begin
         rd_q       <= !we;
         adr_q      <= adr;
         stat_q     <= tb_mvu.stat_chk;
         stat_exp_q <= tb_mvu.exp_stat;
      end else if (ack && rd_q) begin
         rd_q <= 1'b0;
         if (adr_q >= `MVU_A_RES && adr_q < `MVU_A_RES + `MVU_ROWS) begin
            e    = tb_mvu.exp_res[adr_q - `MVU_A_RES]; // handed over by tb
            want = {{16{e[15]}}, e};                   // bus sign extends
            compare("dat_r result", dat_r, want);
         end else if (adr_q == `MVU_A_STATUS) begin
            if (dat_r[1:0] == 2'b11) begin
               chk_cnt++;
               err_cnt++;
               $display("status shows busy and done together at t=%0t", $time);
            end else if (stat_q) begin
               compare("dat_r status", dat_r, stat_exp_q);
            end
         end else if (adr_q != `MVU_A_CTRL) begin
            compare("dat_r unmapped", dat_r, 32'd0);   // unmapped reads give 0
         end
      end
   end

   task automatic end_test(input string name);
      test_cnt++;
      chk_total += chk_cnt;
      err_total += err_cnt;
      $display("test %0d %s: %0d checks, %0d errors, %s",
               test_cnt, name, chk_cnt, err_cnt, (err_cnt == 0) ? "ok" : "bad");
      chk_cnt = 0;
      err_cnt = 0;
   endtask

   task automatic summary();
      $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_total, err_total);
   endtask

endmodule

// File: mvu_assert.sv
// concurrent assertions on the mvu_top bus handshake
// and on the controller busy / done flags
module mvu_assert (
   input logic aclk,
   input logic rst,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic busy,
   input logic done
);
   int fail_cnt = 0;    // read by tb for the final verdict

   a_ack_req: assert property (@(posedge aclk) disable iff (rst) ack |-> $past(cyc && stb))
      else begin fail_cnt++; $error("ack without a bus request"); end

   a_ack_one: assert property (@(posedge aclk) disable iff (rst) ack |=> !ack)
      else begin fail_cnt++; $error("ack high two cycles"); end

   a_busy_done: assert property (@(posedge aclk) disable iff (rst) !(busy && done))
      else begin fail_cnt++; $error("busy and done both high"); end

endmodule

bind mvu_top mvu_assert u_mvu_assert (
   .aclk, .rst, .cyc, .stb, .ack, .busy, .done
);

// File: tb_mvu.sv
// testbench of the matrix-vector unit
// clock, reset, pattern reader, Wishbone driver and watchdog
`include "mvu_params.svh"

module tb_mvu;
   logic                  aclk;
   logic                  rst;
   logic                  cyc;
   logic                  stb;
   logic                  we;
   logic [`MVU_ADR_W-1:0] adr;
   logic [31:0]           dat_w;
   logic [31:0]           dat_r;
   logic                  ack;
   integer                seed;
   logic [15:0]           exp_res [0:3];   // read by the checker
   logic [31:0]           exp_stat;
   logic                  stat_chk;        // exact status compare on
   logic [1:0]            p_op  [0:7];
   logic [15:0]           p_wgt [0:7][0:7];
   logic [15:0]           p_act [0:7][0:1];
   logic [15:0]           p_exp [0:7][0:3];
   int                    n_pat;
   logic                  loaded;
   int                    errs;

   mvu_top u_mvu_top (.aclk, .rst, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

   mvu_checker u_checker (.aclk, .rst, .cyc, .stb, .we, .ack, .adr, .dat_r);

   always #50 aclk = ~aclk;

   task automatic bus_cycle(input logic w, input logic [5:0] a, input logic [31:0] d,
                            output logic [31:0] q);
      @(negedge aclk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = w;
      adr   = a;
      dat_w = d;
      @(negedge aclk);
      while (!ack)
         @(negedge aclk);                // held until ack
      q   = dat_r;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic fold_write(input logic [5:0] a, input logic [15:0] word);
      logic [31:0] pad;
      logic [31:0] q;
      pad = $random(seed);              // upper half is don't care
      bus_cycle(1'b1, a, {pad[31:16], word}, q);
   endtask

   task automatic load_pattern(input int p);
      for (int k = 0; k < 8; k++)
         fold_write(`MVU_A_WGT + k, p_wgt[p][k]);
      for (int f = 0; f < 2; f++)
         fold_write(`MVU_A_ACT + f, p_act[p][f]);
      for (int r = 0; r < 4; r++)
         exp_res[r] = p_exp[p][r];
   endtask

   task automatic start_run(input logic [1:0] op);
      logic [31:0] q;
      bus_cycle(1'b1, `MVU_A_CTRL, {29'd0, op, 1'b1}, q);
   endtask

   // first poll sees busy, then poll until done
   task automatic wait_done();
      logic [31:0] q;
      stat_chk = 1'b1;
      exp_stat = 32'd1;
      bus_cycle(1'b0, `MVU_A_STATUS, 32'd0, q);
      stat_chk = 1'b0;
      while (!q[1])
         bus_cycle(1'b0, `MVU_A_STATUS, 32'd0, q);
      stat_chk = 1'b1;
      exp_stat = 32'd2;                 // sticky done, busy low
      bus_cycle(1'b0, `MVU_A_STATUS, 32'd0, q);
      stat_chk = 1'b0;
   endtask

   task automatic read_results();
      logic [31:0] q;
      for (int r = 0; r < 4; r++)
         bus_cycle(1'b0, `MVU_A_RES + r, 32'd0, q);
   endtask

   task automatic read_patterns();
      int          fd;
      int          n;
      string       line;
      logic [15:0] v [0:14];
      fd = $fopen("mvu_patterns.txt", "r");
      if (fd == 0) begin
         $display("cannot open mvu_patterns.txt");
      end else begin
         while (!$feof(fd) && n_pat < 8) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                           v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
               if (n == 15) begin
                  p_op[n_pat] = v[0][1:0];
                  for (int k = 0; k < 8; k++)
                     p_wgt[n_pat][k] = v[1+k];
                  p_act[n_pat][0] = v[9];
                  p_act[n_pat][1] = v[10];
                  for (int r = 0; r < 4; r++)
                     p_exp[n_pat][r] = v[11+r];
                  n_pat++;
               end
            end
         end
         $fclose(fd);
      end
      if (n_pat == 0)
         $display("no test patterns read from mvu_patterns.txt");
   endtask

   // watchdog, 300 cycles per test
   initial begin
      wait (loaded);
      #((n_pat + 3) * 300 * 100);
      $display("watchdog: simulation ran out of time, DUT never finished");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      logic [31:0] q;
      aclk     = 1'b0;
      rst      = 1'b1;
      cyc      = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = '0;
      dat_w    = '0;
      seed     = 32'hf4fd_c332;
      stat_chk = 1'b0;
      exp_stat = '0;
      n_pat    = 0;
      loaded   = 1'b0;
      for (int r = 0; r < 4; r++)
         exp_res[r] = '0;
      read_patterns();
      loaded = 1'b1;
      repeat (4) @(negedge aclk);
      rst = 1'b0;

      // reset state, status and results read 0
      stat_chk = 1'b1;
      exp_stat = 32'd0;
      bus_cycle(1'b0, `MVU_A_STATUS, 32'd0, q);
      stat_chk = 1'b0;
      read_results();
      u_checker.end_test("reset");

      for (int p = 0; p < n_pat; p++) begin
         load_pattern(p);
         start_run(p_op[p]);
         wait_done();
         read_results();
         u_checker.end_test($sformatf("pattern %0d op %0d", p, p_op[p]));
      end

      // restart clears done, a write while busy is dropped, buffers are reused
      if (n_pat > 0) begin
         start_run(p_op[n_pat-1]);
         fold_write(`MVU_A_ACT, 16'h0000);
         wait_done();
         read_results();
         start_run(p_op[n_pat-1]);
         wait_done();
         read_results();
         u_checker.end_test("reuse");
      end

      bus_cycle(1'b0, 6'h3f, 32'd0, q);
      bus_cycle(1'b0, `MVU_A_WGT, 32'd0, q);
      u_checker.end_test("unmapped");

      repeat (2) @(negedge aclk);
      u_checker.summary();
      errs = u_checker.err_total + u_mvu_top.u_mvu_assert.fail_cnt;
      if (errs == 0 && n_pat > 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+.
mvu_pkg.sv
mvu_wb_regs.sv
mvu_buffers.sv
mvu_fold_counter.sv
mvu_ctrl_fsm.sv
mvu_pe.sv
mvu_top.sv
mvu_checker.sv
mvu_assert.sv
tb_mvu.sv

// File: mvu_patterns.txt
# op w00 w01 w10 w11 w20 w21 w30 w31 (row, fold) act0 act1 res0 res1 res2 res3, all hex
# op 0 signed, 1 unsigned, 2 binary weight; lane 0 in the low nibble of each word
0 1111 1111 ffff ffff 7777 0000 0000 8888 1111 2222 000c fff4 001c ffc0
1 ffff 000f 1234 0002 0000 0000 8888 8888 ffff 0001 0393 0098 0000 01e8
2 1111 1111 0000 0000 0101 0001 eeee ffff 21f3 0088 fff5 000b 0003 ffeb
